// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int instr_w  = 12;
    localparam int nibble_w = 4;
    localparam int index_w  = 12;

    localparam int cycles_per_instr = 7;

    // Bit positions in the flag nibble
    localparam int flag_c = 0;
    localparam int flag_z = 1;
    localparam int flag_d = 2;
    localparam int flag_i = 3;

    typedef enum logic [3:0] {
        op_adc_xh, op_adc_xl, op_adc_yh, op_adc_yl,
        op_adc_rq, op_adc_ri, op_acpx, op_acpy,
        op_ld_ri, op_ld_x, op_ld_y,
        op_set_f, op_rst_f, op_nop
    } op_e;

    typedef enum logic [1:0] {sel_a, sel_b, sel_mx, sel_my} reg_sel_e;

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_rd_req, st_rd_wait,
        st_exec, st_wr_req, st_retire
    } exec_state_e;

endpackage

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int addr_w    = 12;
    localparam int data_w    = 4;
    localparam int ram_depth = 4096;

    // Who drives the RAM this cycle
    typedef enum logic {
        own_core,
        own_host
    } owner_e;

endpackage

`default_nettype wire

// ==== rtl/ram_bus_if.sv ====
`default_nettype none

interface ram_bus_if import mem_pkg::*; ();

    logic              req;
    logic              we;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic              gnt;
    logic [data_w-1:0] rdata;  // Valid the cycle after gnt

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

// ==== rtl/ram_port_if.sv ====
`default_nettype none

interface ram_port_if import mem_pkg::*; ();

    logic              en;
    logic              we;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [data_w-1:0] rdata;

    modport arbiter (output en, we, addr, wdata, input rdata);
    modport ram (input en, we, addr, wdata, output rdata);

endinterface

`default_nettype wire

// ==== rtl/bcd_adder.sv ====
`default_nettype none

module bcd_adder import cpu_pkg::*; (
    input  logic [nibble_w-1:0] a,
    input  logic [nibble_w-1:0] b,
    input  logic                carry_in,
    input  logic                decimal,
    output logic [nibble_w-1:0] sum,
    output logic                carry_out,
    output logic                zero
);

    logic [nibble_w:0] raw;

    assign raw = a + b + carry_in;

    always_comb begin
        if (decimal && raw >= 5'd10) begin
            // Wrap at ten
            sum       = nibble_w'(raw - 5'd10);
            carry_out = 1'b1;
        end else begin
            sum       = raw[nibble_w-1:0];
            carry_out = raw[nibble_w];
        end
    end

    assign zero = (sum == '0);

endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`default_nettype none

module exec_unit import cpu_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    output logic [index_w-1:0]  rom_addr,
    input  logic [instr_w-1:0]  rom_data,
    ram_bus_if.requester        mem,
    output logic [nibble_w-1:0] reg_a,
    output logic [nibble_w-1:0] reg_b,
    output logic [index_w-1:0]  reg_x,
    output logic [index_w-1:0]  reg_y,
    output logic [nibble_w-1:0] flags,
    output logic                instr_done
);

    exec_state_e         state;
    logic [index_w-1:0]  pc;
    logic [instr_w-1:0]  ir;
    op_e                 op;
    reg_sel_e            sel1;  // Destination and first operand
    reg_sel_e            sel2;
    logic [nibble_w-1:0] imm;
    logic                add_op;
    logic                index_op;
    logic                need_rd1;
    logic                need_rd2;
    logic                need_wr;
    logic                rd1_q;
    logic                rd2_q;
    logic [nibble_w-1:0] mem1;
    logic [nibble_w-1:0] mem2;
    logic [nibble_w-1:0] val1;
    logic [nibble_w-1:0] val2;
    logic [nibble_w-1:0] idx_nib;
    logic [nibble_w-1:0] sum;
    logic [nibble_w-1:0] res;
    logic                carry_out;
    logic                zero;
    logic [index_w-1:0]  wr_addr;
    logic [nibble_w-1:0] wr_data;

    always_comb begin
        op   = op_nop;
        sel1 = reg_sel_e'(ir[5:4]);
        sel2 = reg_sel_e'(ir[1:0]);
        casez (ir)
            12'hA0?: op = op_adc_xh;
            12'hA1?: op = op_adc_xl;
            12'hA2?: op = op_adc_yh;
            12'hA3?: op = op_adc_yl;
            12'hA9?: begin
                op   = op_adc_rq;
                sel1 = reg_sel_e'(ir[3:2]);
            end
            12'b1100_01??_????: op = op_adc_ri;
            12'b1111_0010_10??: begin
                op   = op_acpx;
                sel1 = sel_mx;
            end
            12'b1111_0010_11??: begin
                op   = op_acpy;
                sel1 = sel_my;
            end
            12'b1110_00??_????: op = op_ld_ri;
            12'hB??: op = op_ld_x;
            12'h8??: op = op_ld_y;
            12'hF4?: op = op_set_f;
            12'hF5?: op = op_rst_f;
            default: op = op_nop;  // Unsupported opcodes retire quietly
        endcase
    end

    assign imm      = ir[3:0];
    assign add_op   = op inside {op_adc_rq, op_adc_ri, op_acpx, op_acpy};
    assign index_op = op inside {op_adc_xh, op_adc_xl, op_adc_yh, op_adc_yl};
    assign need_rd1 = add_op && (sel1 inside {sel_mx, sel_my});
    assign need_rd2 = (op inside {op_adc_rq, op_acpx, op_acpy}) &&
                      (sel2 inside {sel_mx, sel_my}) && (sel2 != sel1);
    assign need_wr  = (add_op || op == op_ld_ri) && (sel1 inside {sel_mx, sel_my});

    // First memory operand in decode, second in rd_req
    assign mem.req   = (state == st_decode && need_rd1) ||
                       (state == st_rd_req && need_rd2) ||
                       (state == st_wr_req && need_wr);
    assign mem.we    = (state == st_wr_req);
    assign mem.wdata = wr_data;
    always_comb begin
        if (state == st_wr_req)
            mem.addr = wr_addr;
        else if (state == st_decode)
            mem.addr = (sel1 == sel_mx) ? reg_x : reg_y;
        else
            mem.addr = (sel2 == sel_mx) ? reg_x : reg_y;
    end

    always_comb begin
        case (sel1)
            sel_a:   val1 = reg_a;
            sel_b:   val1 = reg_b;
            default: val1 = mem1;
        endcase
        case (sel2)
            sel_a:   val2 = reg_a;
            sel_b:   val2 = reg_b;
            default: val2 = (sel2 == sel1) ? mem1 : mem2;  // Same word read once
        endcase
        case (op)
            op_adc_xh: idx_nib = reg_x[7:4];
            op_adc_xl: idx_nib = reg_x[3:0];
            op_adc_yh: idx_nib = reg_y[7:4];
            default:   idx_nib = reg_y[3:0];
        endcase
    end

    bcd_adder u_adder (
        .a         (index_op ? idx_nib : val1),
        .b         ((index_op || op == op_adc_ri) ? imm : val2),
        .carry_in  (flags[flag_c]),
        .decimal   (flags[flag_d] && !index_op),  // Index adds stay binary
        .sum       (sum),
        .carry_out (carry_out),
        .zero      (zero)
    );

    assign res        = (op == op_ld_ri) ? imm : sum;
    assign rom_addr   = pc;
    assign instr_done = (state == st_retire);

    always_ff @(posedge clk) begin
        if (state == st_fetch && run)
            ir <= rom_data;
        if (rd1_q)
            mem1 <= mem.rdata;
        if (rd2_q)
            mem2 <= mem.rdata;
        if (state == st_exec) begin
            wr_addr <= (sel1 == sel_mx) ? reg_x : reg_y;  // Before ACP increment
            wr_data <= res;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_fetch;
            pc    <= '0;
            reg_a <= '0;
            reg_b <= '0;
            reg_x <= '0;
            reg_y <= '0;
            flags <= '0;
            rd1_q <= 1'b0;
            rd2_q <= 1'b0;
        end else begin
            rd1_q <= (state == st_decode) && need_rd1 && mem.gnt;
            rd2_q <= (state == st_rd_req) && need_rd2 && mem.gnt;
            case (state)
                st_fetch:   if (run) state <= st_decode;
                st_decode:  if (!need_rd1 || mem.gnt) state <= st_rd_req;
                st_rd_req:  if (!need_rd2 || mem.gnt) state <= st_rd_wait;
                st_rd_wait: state <= st_exec;
                st_exec:    state <= st_wr_req;
                st_wr_req:  if (!need_wr || mem.gnt) state <= st_retire;
                st_retire: begin
                    state <= st_fetch;
                    pc    <= pc + 1'b1;
                end
                default:    state <= st_fetch;
            endcase
            if (state == st_exec) begin
                if (index_op || add_op) begin
                    flags[flag_c] <= carry_out;
                    flags[flag_z] <= zero;
                end
                case (op)
                    op_adc_xh: reg_x[7:4] <= sum;
                    op_adc_xl: reg_x[3:0] <= sum;
                    op_adc_yh: reg_y[7:4] <= sum;
                    op_adc_yl: reg_y[3:0] <= sum;
                    op_adc_rq, op_adc_ri, op_ld_ri: begin
                        if (sel1 == sel_a)
                            reg_a <= res;
                        if (sel1 == sel_b)
                            reg_b <= res;
                    end
                    op_acpx:  reg_x[7:0] <= reg_x[7:0] + 8'd1;  // XP untouched
                    op_acpy:  reg_y[7:0] <= reg_y[7:0] + 8'd1;
                    op_ld_x:  reg_x[7:0] <= ir[7:0];
                    op_ld_y:  reg_y[7:0] <= ir[7:0];
                    op_set_f: flags <= flags | imm;
                    op_rst_f: flags <= flags & imm;
                    default:  ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ram_arbiter.sv ====
`default_nettype none

module ram_arbiter import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    ram_bus_if.arbiter core,
    ram_bus_if.arbiter host,
    ram_port_if.arbiter ram
);

    owner_e owner;
    owner_e rd_owner;  // Side the RAM output word belongs to

    // Core always wins
    assign owner    = core.req ? own_core : own_host;
    assign core.gnt = core.req;
    assign host.gnt = host.req && !core.req;

    assign ram.en    = core.req || host.req;
    assign ram.we    = (owner == own_core) ? core.we : host.we;
    assign ram.addr  = (owner == own_core) ? core.addr : host.addr;
    assign ram.wdata = (owner == own_core) ? core.wdata : host.wdata;

    always_ff @(posedge clk) begin
        if (rst)
            rd_owner <= own_core;
        else if (ram.en)
            rd_owner <= owner;
    end

    assign core.rdata = (rd_owner == own_core) ? ram.rdata : '0;
    assign host.rdata = (rd_owner == own_host) ? ram.rdata : '0;

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
`default_nettype none

module data_ram import mem_pkg::*; (
    input  logic   clk,
    ram_port_if.ram ram
);

    logic [data_w-1:0] mem [ram_depth];

    // Read before write on the same address
    always_ff @(posedge clk) begin
        if (ram.en) begin
            if (ram.we)
                mem[ram.addr] <= ram.wdata;
            ram.rdata <= mem[ram.addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_core_top.sv ====
`default_nettype none

module cpu_core_top import cpu_pkg::*, mem_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    output logic [index_w-1:0]  rom_addr,
    input  logic [instr_w-1:0]  rom_data,
    input  logic                host_req,
    input  logic                host_we,
    input  logic [addr_w-1:0]   host_addr,
    input  logic [data_w-1:0]   host_wdata,
    output logic                host_gnt,
    output logic [data_w-1:0]   host_rdata,
    output logic [nibble_w-1:0] reg_a,
    output logic [nibble_w-1:0] reg_b,
    output logic [index_w-1:0]  reg_x,
    output logic [index_w-1:0]  reg_y,
    output logic [nibble_w-1:0] flags,
    output logic                instr_done
);

    ram_bus_if  core_bus ();
    ram_bus_if  host_bus ();
    ram_port_if ram_port ();

    // Host side of the shared RAM
    assign host_bus.req   = host_req;
    assign host_bus.we    = host_we;
    assign host_bus.addr  = host_addr;
    assign host_bus.wdata = host_wdata;
    assign host_gnt       = host_bus.gnt;
    assign host_rdata     = host_bus.rdata;

    exec_unit u_exec (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .mem        (core_bus),
        .reg_a      (reg_a),
        .reg_b      (reg_b),
        .reg_x      (reg_x),
        .reg_y      (reg_y),
        .flags      (flags),
        .instr_done (instr_done)
    );

    ram_arbiter u_arbiter (
        .clk  (clk),
        .rst  (rst),
        .core (core_bus),
        .host (host_bus),
        .ram  (ram_port)
    );

    data_ram u_ram (
        .clk (clk),
        .ram (ram_port)
    );

endmodule

`default_nettype wire

// ==== tb/cpu_core_tb.sv ====
`default_nettype none

module cpu_core_tb import cpu_pkg::*, mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] lfsr_seed = 16'd48991;
    localparam int wait_limit = 200;   // Clocks per wait loop
    localparam logic [instr_w-1:0] nop_op = 12'hFFF;

    logic                clk;
    logic                rst;
    logic                run;
    logic [index_w-1:0]  rom_addr;
    logic [instr_w-1:0]  rom_data;
    logic                host_req;
    logic                host_we;
    logic [addr_w-1:0]   host_addr;
    logic [data_w-1:0]   host_wdata;
    logic                host_gnt;
    logic [data_w-1:0]   host_rdata;
    logic [nibble_w-1:0] reg_a;
    logic [nibble_w-1:0] reg_b;
    logic [index_w-1:0]  reg_x;
    logic [index_w-1:0]  reg_y;
    logic [nibble_w-1:0] flags;
    logic                instr_done;

    logic [instr_w-1:0]  rom [2**index_w];
    logic [instr_w-1:0]  pbuf [0:15];
    int                  plen;
    int                  done_cycle [0:15];
    logic [index_w-1:0]  done_pc [0:15];
    logic [15:0]         lfsr_state;
    int                  cycle_cnt = 0;
    int                  tests;
    int                  checks;
    int                  errors;

    cpu_core_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_gnt   (host_gnt),
        .host_rdata (host_rdata),
        .reg_a      (reg_a),
        .reg_b      (reg_b),
        .reg_x      (reg_x),
        .reg_y      (reg_y),
        .flags      (flags),
        .instr_done (instr_done)
    );

    assign rom_data = rom[rom_addr];  // Combinational fetch

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Galois LFSR stepped once per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return v;
    endfunction

    // Sum with the carry in bit 4
    function automatic logic [nibble_w:0] ref_add(input logic [nibble_w-1:0] a, b,
                                                  input logic c, dec);
        int s;
        logic [nibble_w:0] r;
        s = a + b + c;
        if (dec && s >= 10) begin  // Decimal sums wrap at ten
            r[nibble_w] = 1'b1;
            r[nibble_w-1:0] = s - 10;
        end else begin
            r = s;
        end
        return r;
    endfunction

    function automatic logic [nibble_w-1:0] exp_flags(input logic dec,
                                                      input logic [nibble_w:0] r);
        logic [nibble_w-1:0] f;
        f = '0;
        f[flag_d] = dec;
        f[flag_c] = r[nibble_w];
        f[flag_z] = (r[nibble_w-1:0] == '0);
        return f;
    endfunction

    task automatic finish_run();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        errors++;
        $display("Timed out waiting for %s", what);
        finish_run();
    endtask

    task automatic compare_nibble(input string name, input logic [nibble_w-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_index(input string name, input logic [index_w-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("test %s done, %0d errors", name, errors - err0);
    endtask

    // Bus tasks enter and leave 2 ns after a rising edge
    task automatic host_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        int t;
        host_req   = 1'b1;
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        t = 0;
        @(negedge clk);
        while (!host_gnt && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (!host_gnt)
            timeout_abort("host write grant");
        @(posedge clk);
        #2;
        host_req = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic host_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
        int t;
        host_req  = 1'b1;
        host_we   = 1'b0;
        host_addr = addr;
        t = 0;
        @(negedge clk);
        while (!host_gnt && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (!host_gnt)
            timeout_abort("host read grant");
        @(posedge clk);
        #2;
        host_req = 1'b0;
        @(negedge clk);
        data = host_rdata;  // One cycle after grant
        @(posedge clk);
        #2;
    endtask

    task automatic emit(input logic [instr_w-1:0] code);
        pbuf[plen] = code;
        plen++;
    endtask

    // Place program at the current PC and run until all of it retired
    task automatic run_prog();
        int done;
        int t;
        logic [index_w-1:0] base;
        base = rom_addr;
        for (int i = 0; i < plen; i++)
            rom[base + i] = pbuf[i];
        run = 1'b1;
        done = 0;
        t = 0;
        while (done < plen && t < wait_limit) begin
            @(negedge clk);
            t++;
            if (instr_done) begin
                done_cycle[done] = cycle_cnt;
                done_pc[done]    = rom_addr;
                done++;
            end
        end
        if (done < plen)
            timeout_abort("instr_done");
        @(posedge clk);
        #2;
        run  = 1'b0;
        plen = 0;
    endtask

    task automatic index_adds();
        int err0;
        logic [nibble_w:0] e;
        err0 = errors;
        emit(12'hF50);
        emit(12'hB22);
        emit(12'hA0F);  // ADC XH,F
        run_prog();
        e = ref_add(4'h2, 4'hF, 1'b0, 1'b0);
        compare_index("reg_x", reg_x, {4'h0, e[3:0], 4'h2});
        compare_nibble("flags", flags, exp_flags(1'b0, e));
        emit(12'hF50);
        emit(12'h833);
        emit(12'hA3D);  // ADC YL,D
        run_prog();
        e = ref_add(4'h3, 4'hD, 1'b0, 1'b0);
        compare_index("reg_y", reg_y, {4'h0, 4'h3, e[3:0]});
        compare_nibble("flags", flags, exp_flags(1'b0, e));
        report_test("index_adds", err0);
    endtask

    task automatic binary_adc_pairs();
        int err0;
        logic [nibble_w-1:0] va, vb, rd;
        logic [nibble_w-1:0] vals [4];
        logic [nibble_w:0] e;
        logic c;
        err0 = errors;
        for (int r = 0; r < 4; r++) begin
            for (int q = 0; q < 4; q++) begin
                va = rand_bits(4);
                vb = rand_bits(4);
                c  = rand_bits(1);
                host_write(12'h010, 4'h4);
                host_write(12'h020, 4'hB);
                emit(12'hB10);
                emit(12'h820);
                emit(12'hE00 | va);
                emit(12'hE10 | vb);
                emit(c ? 12'hF41 : 12'hF5E);
                emit(12'hA90 | (r << 2) | q);
                run_prog();
                vals[0] = va;
                vals[1] = vb;
                vals[2] = 4'h4;
                vals[3] = 4'hB;
                e = ref_add(vals[r], vals[q], c, 1'b0);
                compare_nibble("reg_a", reg_a, (r == 0) ? e[3:0] : va);
                compare_nibble("reg_b", reg_b, (r == 1) ? e[3:0] : vb);
                host_read(12'h010, rd);
                compare_nibble("ram_mx", rd, (r == 2) ? e[3:0] : 4'h4);
                host_read(12'h020, rd);
                compare_nibble("ram_my", rd, (r == 3) ? e[3:0] : 4'hB);
                compare_nibble("flags", flags, exp_flags(1'b0, e));
            end
        end
        report_test("binary_adc_pairs", err0);
    endtask

    task automatic acp_writeback();
        int err0;
        logic [nibble_w-1:0] a, b, m1, m2, rd;
        logic [nibble_w:0] e1, e2;
        err0 = errors;
        a  = rand_bits(4);
        b  = rand_bits(4);
        m1 = rand_bits(4);
        m2 = rand_bits(4);
        host_write(12'h03E, m1);
        host_write(12'h05F, m2);
        emit(12'hB3E);
        emit(12'h85F);
        emit(12'hE00 | a);
        emit(12'hE10 | b);
        emit(12'hF5E);
        emit(12'hF28);  // ACPX MX,A
        emit(12'hF2D);  // ACPY MY,B
        run_prog();
        e1 = ref_add(m1, a, 1'b0, 1'b0);
        e2 = ref_add(m2, b, e1[4], 1'b0);
        host_read(12'h03E, rd);
        compare_nibble("ram_mx", rd, e1[3:0]);
        host_read(12'h05F, rd);
        compare_nibble("ram_my", rd, e2[3:0]);
        compare_index("reg_x", reg_x, 12'h03F);
        compare_index("reg_y", reg_y, 12'h060);
        compare_nibble("reg_a", reg_a, a);
        compare_nibble("reg_b", reg_b, b);
        compare_nibble("flags", flags, exp_flags(1'b0, e2));
        report_test("acp_writeback", err0);
    endtask

    task automatic nop_timing_and_sharing();
        int err0;
        int t;
        logic [index_w-1:0] base;
        logic [nibble_w-1:0] a, m, w, rd;
        logic [nibble_w:0] e;
        logic gnt_seen;
        err0 = errors;
        base = rom_addr;
        host_req  = 1'b1;  // Read requests held for the whole NOP run
        host_we   = 1'b0;
        host_addr = 12'h010;
        for (int i = 0; i < 6; i++)
            emit(nop_op);
        run_prog();
        host_req = 1'b0;
        for (int i = 0; i < 6; i++) begin
            compare_index("rom_addr", done_pc[i], base + index_w'(i));
            if (i > 0 && done_cycle[i] - done_cycle[i-1] != cycles_per_instr) begin
                errors++;
                $display("instr_done pulses %0d clocks apart instead of %0d",
                         done_cycle[i] - done_cycle[i-1], cycles_per_instr);
            end
        end
        a = rand_bits(4);
        m = rand_bits(4);
        w = rand_bits(4);
        host_write(12'h070, m);
        emit(12'hB70);
        emit(12'hE00 | a);
        emit(12'hF5E);
        emit(12'hF28);
        base = rom_addr;
        fork
            run_prog();
            begin
                t = 0;
                while (rom_addr != base + 3 && t < wait_limit) begin
                    @(negedge clk);
                    t++;
                end
                if (rom_addr != base + 3)
                    timeout_abort("ACPX fetch");
                @(posedge clk);
                #2;
                host_write(12'h0A5, w);  // Lands while ACPX owns the bus
                host_req  = 1'b1;        // Read held over the ACPX write-back
                host_we   = 1'b0;
                host_addr = 12'h0A5;
                gnt_seen  = 1'b0;
                t = 0;
                @(negedge clk);
                while (!instr_done && t < wait_limit) begin
                    gnt_seen = host_gnt;
                    @(negedge clk);
                    t++;
                end
                if (!instr_done)
                    timeout_abort("ACPX retire");
                compare_bit("host_gnt", gnt_seen, 1'b0);  // Core writes MX before retire
                @(posedge clk);
                #2;
                host_req = 1'b0;
            end
        join
        host_read(12'h0A5, rd);
        compare_nibble("host_rdata", rd, w);
        host_read(12'h070, rd);
        e = ref_add(m, a, 1'b0, 1'b0);
        compare_nibble("ram_mx", rd, e[3:0]);
        compare_index("reg_x", reg_x, 12'h071);
        report_test("nop_timing_and_sharing", err0);
    endtask

    task automatic decimal_adc();
        int err0;
        logic [nibble_w-1:0] a, b, i;
        logic [nibble_w:0] s1, s2;
        logic c;
        err0 = errors;
        for (int n = 0; n < 8; n++) begin
            a = rand_bits(4) % 10;
            b = rand_bits(4) % 10;
            i = rand_bits(4) % 10;
            c = rand_bits(1);
            emit(12'hF50);
            emit(12'hF44 | c);
            emit(12'hE00 | a);
            emit(12'hE10 | b);
            emit(12'hC40 | i);  // ADC A,i
            emit(12'hA94);      // ADC B,A
            run_prog();
            s1 = ref_add(a, i, c, 1'b1);
            s2 = ref_add(b, s1[3:0], s1[4], 1'b1);
            compare_nibble("reg_a", reg_a, s1[3:0]);
            compare_nibble("reg_b", reg_b, s2[3:0]);
            compare_nibble("flags", flags, exp_flags(1'b1, s2));
        end
        report_test("decimal_adc", err0);
    endtask

    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        lfsr_state = lfsr_seed;
        plen       = 0;
        tests      = 0;
        checks     = 0;
        errors     = 0;
        // Idle fill stays in the 0xx to 7xx range, which decodes as NOP
        for (int i = 0; i < 2**index_w; i++)
            rom[i] = (i ^ (i >> 6)) & 12'h7FF;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        compare_index("rom_addr", rom_addr, '0);
        compare_nibble("flags", flags, '0);
        index_adds();
        binary_adc_pairs();
        acp_writeback();
        nop_timing_and_sharing();
        decimal_adc();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/cpu_pkg.sv
rtl/mem_pkg.sv
rtl/ram_bus_if.sv
rtl/ram_port_if.sv
rtl/bcd_adder.sv
rtl/exec_unit.sv
rtl/ram_arbiter.sv
rtl/data_ram.sv
rtl/cpu_core_top.sv
tb/cpu_core_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - rtl/cpu_pkg.sv
  - rtl/mem_pkg.sv
  - rtl/ram_bus_if.sv
  - rtl/ram_port_if.sv
  - rtl/bcd_adder.sv
  - rtl/exec_unit.sv
  - rtl/ram_arbiter.sv
  - rtl/data_ram.sv
  - rtl/cpu_core_top.sv
  - target: test
    files:
      - tb/cpu_core_tb.sv
